/* verilog/zxuno_defines.svh */
`ifndef ZXUNO_DEFINES_SVH
`define ZXUNO_DEFINES_SVH

// ---------------------------------------------------------------------------
// ZX-Uno I/O port addresses
// ---------------------------------------------------------------------------
`define ZXUNO_ADDR_PORT 16'hFC3B
`define ZXUNO_DATA_PORT 16'hFD3B

// Register numbers behind the data port
`define REG_DEVOPTIONS 8'h0E
`define REG_SCRATCH    8'hFE
`define REG_COREID     8'hFF

// Bytes forced onto the CPU data-in bus
`define INTACK_DATA  8'hFF
`define FLOATING_BUS 8'hFF

// ---------------------------------------------------------------------------
// Core-ID string, "T1.0A" plus terminator
// ---------------------------------------------------------------------------
`define COREID_LEN   6
`define COREID_BYTE0 8'h54
`define COREID_BYTE1 8'h31
`define COREID_BYTE2 8'h2E
`define COREID_BYTE3 8'h30
`define COREID_BYTE4 8'h41
// Terminator
`define COREID_BYTE5 8'h00

`endif

/* verilog/zxuno_pkg.sv */
package zxuno_pkg;

  // Bus widths
  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0]  cpu_data_t;
  typedef logic [7:0]  reg_addr_t;

  // One cycle of the Z80 bus as seen by the I/O side
  typedef struct packed {
    cpu_addr_t addr;
    cpu_data_t dout;
    logic      iorq_n;
    logic      rd_n;
    logic      wr_n;
    logic      m1_n;
  } cpu_bus_t;

  // Register access from the port decoder to the register blocks
  typedef struct packed {
    reg_addr_t addr;
    // Level, data port read in progress
    logic      rd;
    // First cycle of a data port write
    logic      wr_stb;
    cpu_data_t wdata;
    // One cycle after a data port read ends
    logic      rd_done;
    // Register address port was written
    logic      addr_changed;
  } reg_access_t;

  // Device-options register, bit 7 down to bit 0
  typedef struct packed {
    logic disable_ay;
    logic disable_turboay;
    logic disable_7ffd;
    logic disable_1ffd;
    logic disable_romsel7f;
    logic disable_romsel1f;
    logic enable_timexmmu;
    logic disable_spisd;
  } dev_options_t;

endpackage

/* verilog/zxuno_port_decode.sv */
`timescale 1ns/1ns
`include "zxuno_defines.svh"

module zxuno_port_decode
  import zxuno_pkg::*;
(
  input  logic        sysclk,
  input  logic        rst,
  input  cpu_bus_t    bus,
  output reg_access_t access,
  output logic        addr_rd,
  output reg_addr_t   reg_addr
);

  // I/O cycle qualifiers, interrupt acknowledge excluded
  logic io_rd;
  logic io_wr;
  logic hit_addr_port;
  logic hit_data_port;
  logic data_rd;
  logic addr_wr_stb;

  // Strobe state one cycle back
  logic wr_q;
  logic data_rd_q;

  assign io_rd = !bus.iorq_n && !bus.rd_n && bus.wr_n && bus.m1_n;
  assign io_wr = !bus.iorq_n && !bus.wr_n && bus.rd_n && bus.m1_n;

  assign hit_addr_port = (bus.addr == `ZXUNO_ADDR_PORT);
  assign hit_data_port = (bus.addr == `ZXUNO_DATA_PORT);

  assign data_rd = io_rd && hit_data_port;
  assign addr_rd = io_rd && hit_addr_port;

  // Only the first cycle of a held write counts
  assign addr_wr_stb = io_wr && !wr_q && hit_addr_port;

  // ---------------------------------------------------------------------------
  // Address register and edge history
  // ---------------------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      wr_q      <= 1'b0;
      data_rd_q <= 1'b0;
      reg_addr  <= '0;
    end else begin
      wr_q      <= io_wr;
      data_rd_q <= data_rd;
      // New register number lands at end of first write cycle
      if (addr_wr_stb) begin
        reg_addr <= bus.dout;
      end
    end
  end

  // Access bundle for the register blocks
  always_comb begin
    access.addr         = reg_addr;
    access.rd           = data_rd;
    access.wr_stb       = io_wr && !wr_q && hit_data_port;
    access.wdata        = bus.dout;
    // First idle cycle after the read
    access.rd_done      = data_rd_q && !data_rd;
    access.addr_changed = addr_wr_stb;
  end

  // One strobe per write however long it is held
  wr_stb_single: assert property (
    @(posedge sysclk) disable iff (rst)
    access.wr_stb |=> !access.wr_stb
  );

  // Read and write of the data port never overlap
  rd_wr_excl: assert property (
    @(posedge sysclk) disable iff (rst)
    !(access.rd && access.wr_stb)
  );

endmodule

/* verilog/zxuno_reg_bank.sv */
`timescale 1ns/1ns
`include "zxuno_defines.svh"

module zxuno_reg_bank
  import zxuno_pkg::*;
(
  input  logic         sysclk,
  input  logic         rst,
  input  reg_access_t  access,
  output logic         bank_oe,
  output cpu_data_t    bank_dout,
  output dev_options_t dev_options
);

  // Address matches for this bank
  logic sel_scratch;
  logic sel_devopts;

  cpu_data_t scratch;

  assign sel_scratch = (access.addr == `REG_SCRATCH);
  assign sel_devopts = (access.addr == `REG_DEVOPTIONS);

  // ---------------------------------------------------------------------------
  // Register writes
  // ---------------------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      scratch     <= '0;
      dev_options <= '0;
    end else if (access.wr_stb) begin
      if (sel_scratch) begin
        scratch <= access.wdata;
      end
      // Flags map straight onto data bits 7..0
      if (sel_devopts) begin
        dev_options <= dev_options_t'(access.wdata);
      end
    end
  end

  // Readback
  assign bank_oe   = access.rd && (sel_scratch || sel_devopts);
  assign bank_dout = sel_devopts ? cpu_data_t'(dev_options) : scratch;

  // Bank never answers for the core-ID register
  no_coreid_overlap: assert property (
    @(posedge sysclk) disable iff (rst)
    bank_oe |-> (access.addr != `REG_COREID)
  );

endmodule

/* verilog/zxuno_coreid.sv */
`timescale 1ns/1ns
`include "zxuno_defines.svh"

module zxuno_coreid
  import zxuno_pkg::*;
(
  input  logic        sysclk,
  input  logic        rst,
  input  reg_access_t access,
  output logic        coreid_oe,
  output cpu_data_t   coreid_dout
);

  // Index into the ID string
  logic [2:0] ptr;
  logic       sel_coreid;

  assign sel_coreid = (access.addr == `REG_COREID);

  // Restart on address write, step once per finished read
  always_ff @(posedge sysclk) begin
    if (rst || access.addr_changed) begin
      ptr <= '0;
    end else if (access.rd_done && sel_coreid) begin
      // Wrap after the terminator
      ptr <= (ptr == 3'(`COREID_LEN - 1)) ? 3'd0 : ptr + 3'd1;
    end
  end

  always_comb begin
    case (ptr)
      3'd0:    coreid_dout = `COREID_BYTE0;
      3'd1:    coreid_dout = `COREID_BYTE1;
      3'd2:    coreid_dout = `COREID_BYTE2;
      3'd3:    coreid_dout = `COREID_BYTE3;
      3'd4:    coreid_dout = `COREID_BYTE4;
      default: coreid_dout = `COREID_BYTE5;
    endcase
  end

  assign coreid_oe = access.rd && sel_coreid;

  ptr_in_range: assert property (
    @(posedge sysclk) disable iff (rst)
    ptr < 3'(`COREID_LEN)
  );

endmodule

/* verilog/cpu_din_mux.sv */
`timescale 1ns/1ns
`include "zxuno_defines.svh"

module cpu_din_mux
  import zxuno_pkg::*;
(
  input  cpu_bus_t  bus,
  input  logic      addr_rd,
  input  reg_addr_t reg_addr,
  input  logic      bank_oe,
  input  cpu_data_t bank_dout,
  input  logic      coreid_oe,
  input  cpu_data_t coreid_dout,
  output cpu_data_t cpudin
);

  // Interrupt acknowledge, IORQ together with M1
  logic intack;

  assign intack = !bus.iorq_n && !bus.m1_n;

  // ---------------------------------------------------------------------------
  // Priority order, first match wins
  // ---------------------------------------------------------------------------
  always_comb begin
    if (intack) begin
      cpudin = `INTACK_DATA;
    end else if (addr_rd) begin
      // Register address port readback
      cpudin = reg_addr;
    end else if (coreid_oe) begin
      cpudin = coreid_dout;
    end else if (bank_oe) begin
      cpudin = bank_dout;
    end else begin
      // Nothing driving the bus
      cpudin = `FLOATING_BUS;
    end
  end

endmodule

/* verilog/zxuno_io.sv */
`timescale 1ns/1ns

module zxuno_io
  import zxuno_pkg::*;
(
  input  logic         sysclk,
  input  logic         rst,
  input  cpu_bus_t     bus,
  output cpu_data_t    cpudin,
  output dev_options_t dev_options
);

  // Decoder outputs
  reg_access_t access;
  logic        addr_rd;
  reg_addr_t   reg_addr;

  // Register block read paths
  logic      bank_oe;
  cpu_data_t bank_dout;
  logic      coreid_oe;
  cpu_data_t coreid_dout;

  zxuno_port_decode u_decode (
    .sysclk   (sysclk),
    .rst      (rst),
    .bus      (bus),
    .access   (access),
    .addr_rd  (addr_rd),
    .reg_addr (reg_addr)
  );

  // Scratch and device options
  zxuno_reg_bank u_reg_bank (
    .sysclk      (sysclk),
    .rst         (rst),
    .access      (access),
    .bank_oe     (bank_oe),
    .bank_dout   (bank_dout),
    .dev_options (dev_options)
  );

  zxuno_coreid u_coreid (
    .sysclk      (sysclk),
    .rst         (rst),
    .access      (access),
    .coreid_oe   (coreid_oe),
    .coreid_dout (coreid_dout)
  );

  // CPU data-in selection
  cpu_din_mux u_din_mux (
    .bus         (bus),
    .addr_rd     (addr_rd),
    .reg_addr    (reg_addr),
    .bank_oe     (bank_oe),
    .bank_dout   (bank_dout),
    .coreid_oe   (coreid_oe),
    .coreid_dout (coreid_dout),
    .cpudin      (cpudin)
  );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic sysclk,
  output logic rst
);

  localparam int HALF_PERIOD_NS = 5;

  // Free running 100 MHz clock
  initial begin
    sysclk = 1'b0;
    forever #HALF_PERIOD_NS sysclk = ~sysclk;
  end

  // Reset held over the first two rising edges
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge sysclk);
    #1 rst = 1'b0;
  end

endmodule

/* tb/tb_zxuno_io.sv */
`timescale 1ns/1ns
`include "zxuno_defines.svh"

module tb_zxuno_io
  import zxuno_pkg::*;
();

  localparam int NUM_RANDOM = 400;
  localparam int CLK_PERIOD_NS = 10;
  // Longest access is 4 active plus 2 idle cycles
  localparam int MAX_ACCESS_CYCLES = 6;
  // Random accesses plus the directed opening and some slack
  localparam int TIMEOUT_NS = (NUM_RANDOM + 40) * MAX_ACCESS_CYCLES * CLK_PERIOD_NS + 500;

  logic         sysclk;
  logic         rst;
  cpu_bus_t     bus;
  cpu_data_t    cpudin;
  dev_options_t dev_options;
  integer       seed;

  // Reference model state
  reg_addr_t m_reg_addr;
  cpu_data_t m_scratch;
  cpu_data_t m_options;
  int        m_ptr;

  tb_clk_gen u_clk_gen (
    .sysclk (sysclk),
    .rst    (rst)
  );

  zxuno_io DUT (
    .sysclk      (sysclk),
    .rst         (rst),
    .bus         (bus),
    .cpudin      (cpudin),
    .dev_options (dev_options)
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic int rand_between(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // ASCII of the ID text and a zero byte after its last character
  function automatic cpu_data_t coreid_byte(input int idx);
    string id;
    id = "T1.0A";
    if (idx < id.len()) begin
      return id[idx];
    end
    return 8'h00;
  endfunction

  // Flags listed from bit 7 down
  function automatic dev_options_t options_from_byte(input cpu_data_t b);
    dev_options_t o;
    o.disable_ay       = b[7];
    o.disable_turboay  = b[6];
    o.disable_7ffd     = b[5];
    o.disable_1ffd     = b[4];
    o.disable_romsel7f = b[3];
    o.disable_romsel1f = b[2];
    o.enable_timexmmu  = b[1];
    o.disable_spisd    = b[0];
    return o;
  endfunction

  function automatic cpu_data_t expected_data_read();
    case (m_reg_addr)
      `REG_COREID:     return coreid_byte(m_ptr);
      `REG_SCRATCH:    return m_scratch;
      `REG_DEVOPTIONS: return m_options;
      default:         return `FLOATING_BUS;
    endcase
  endfunction

  // Mostly the three real registers and now and then an empty slot
  function automatic reg_addr_t pick_reg_number();
    case (rand_between(0, 3))
      0:       return `REG_SCRATCH;
      1:       return `REG_DEVOPTIONS;
      2:       return `REG_COREID;
      default: return reg_addr_t'($random(seed));
    endcase
  endfunction

  function automatic cpu_addr_t unmapped_port();
    cpu_addr_t a;
    a = cpu_addr_t'($random(seed));
    // Flipping the top bit moves off both ports
    if (a == `ZXUNO_ADDR_PORT || a == `ZXUNO_DATA_PORT) begin
      a = a ^ 16'h8000;
    end
    return a;
  endfunction

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [7:0] exp,
                                 input logic [7:0] got);
    $display("[FAIL] %0t ns: %s expected %02h, got %02h", $time, sig, exp, got);
    abort_run();
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge sysclk);
    #1;
  endtask

  task automatic drive_idle();
    bus = '{addr: '0, dout: '0, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1};
  endtask

  // --------------------------------------------------------------------------
  // Bus cycles are entered and left 1 ns after an edge
  // --------------------------------------------------------------------------
  task automatic io_write(input cpu_addr_t addr, input cpu_data_t data,
                          input int hold, input int idle);
    bus.addr   = addr;
    bus.dout   = data;
    bus.iorq_n = 1'b0;
    bus.wr_n   = 1'b0;
    repeat (hold) next_cycle();
    drive_idle();
    if (addr == `ZXUNO_ADDR_PORT) begin
      m_reg_addr = data;
      m_ptr      = 0;
    end else if (addr == `ZXUNO_DATA_PORT) begin
      if (m_reg_addr == `REG_SCRATCH) begin
        m_scratch = data;
      end
      if (m_reg_addr == `REG_DEVOPTIONS) begin
        m_options = data;
      end
    end
    // Write has landed by the middle of the idle cycle
    #4;
    opts_check: assert (dev_options === options_from_byte(m_options))
      else report_mismatch("dev_options", options_from_byte(m_options), dev_options);
    repeat (idle) next_cycle();
  endtask

  task automatic io_read(input cpu_addr_t addr, input int hold, input int idle);
    cpu_data_t exp;
    bus.addr   = addr;
    bus.iorq_n = 1'b0;
    bus.rd_n   = 1'b0;
    repeat (hold - 1) next_cycle();
    #4;
    if (addr == `ZXUNO_ADDR_PORT) begin
      exp = m_reg_addr;
    end else if (addr == `ZXUNO_DATA_PORT) begin
      exp = expected_data_read();
    end else begin
      exp = `FLOATING_BUS;
    end
    read_check: assert (cpudin === exp)
      else report_mismatch("cpudin", exp, cpudin);
    // One step per finished ID read however long it was held
    if (addr == `ZXUNO_DATA_PORT && m_reg_addr == `REG_COREID) begin
      m_ptr = (m_ptr + 1) % `COREID_LEN;
    end
    next_cycle();
    drive_idle();
    repeat (idle) next_cycle();
  endtask

  task automatic int_ack(input cpu_addr_t addr, input int hold, input int idle);
    bus.addr   = addr;
    bus.iorq_n = 1'b0;
    bus.m1_n   = 1'b0;
    repeat (hold - 1) next_cycle();
    #4;
    intack_check: assert (cpudin === `INTACK_DATA)
      else report_mismatch("cpudin", `INTACK_DATA, cpudin);
    next_cycle();
    drive_idle();
    repeat (idle) next_cycle();
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    int        kind;
    int        hold;
    int        idle;
    cpu_data_t data;
    seed       = 32'h08aee916;
    m_reg_addr = '0;
    m_scratch  = '0;
    m_options  = '0;
    m_ptr      = 0;
    drive_idle();
    wait (rst === 1'b0);
    next_cycle();

    // Reset values then scratch and options round trips
    io_read(`ZXUNO_ADDR_PORT, 2, 1);
    io_write(`ZXUNO_ADDR_PORT, `REG_SCRATCH, 2, 1);
    io_read(`ZXUNO_DATA_PORT, 2, 1);
    io_write(`ZXUNO_DATA_PORT, 8'hA5, 3, 1);
    io_read(`ZXUNO_DATA_PORT, 4, 2);
    io_write(`ZXUNO_ADDR_PORT, `REG_DEVOPTIONS, 2, 1);
    io_read(`ZXUNO_DATA_PORT, 2, 1);
    io_write(`ZXUNO_DATA_PORT, 8'hC4, 2, 1);
    io_read(`ZXUNO_DATA_PORT, 2, 1);

    // Whole ID string past the wrap with some reads held long
    io_write(`ZXUNO_ADDR_PORT, `REG_COREID, 2, 1);
    for (int i = 0; i < 8; i++) begin
      io_read(`ZXUNO_DATA_PORT, 2 + (i % 3), 1);
    end
    io_write(`ZXUNO_ADDR_PORT, `REG_COREID, 2, 2);
    io_read(`ZXUNO_DATA_PORT, 2, 1);
    int_ack(`ZXUNO_DATA_PORT, 3, 1);
    io_write(`ZXUNO_ADDR_PORT, 8'h42, 2, 1);
    io_read(`ZXUNO_DATA_PORT, 2, 1);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      kind = rand_between(0, 9);
      hold = rand_between(2, 4);
      idle = rand_between(1, 2);
      data = cpu_data_t'($random(seed));
      case (kind)
        0, 1:    io_write(`ZXUNO_ADDR_PORT, pick_reg_number(), hold, idle);
        2:       io_read(`ZXUNO_ADDR_PORT, hold, idle);
        3:       io_write(`ZXUNO_DATA_PORT, data, hold, idle);
        4, 5, 6: io_read(`ZXUNO_DATA_PORT, hold, idle);
        7:       int_ack(cpu_addr_t'($random(seed)), hold, idle);
        8:       io_read(unmapped_port(), hold, idle);
        default: io_write(unmapped_port(), data, hold, idle);
      endcase
    end

    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the test sequence did not complete within %0d ns", TIMEOUT_NS);
    abort_run();
  end

endmodule

/* project.f */
+incdir+verilog
verilog/zxuno_pkg.sv
verilog/zxuno_port_decode.sv
verilog/zxuno_reg_bank.sv
verilog/zxuno_coreid.sv
verilog/cpu_din_mux.sv
verilog/zxuno_io.sv
tb/tb_clk_gen.sv
tb/tb_zxuno_io.sv

/* Bender.yml */
package:
  name: zxuno_io

export_include_dirs:
  - verilog

sources:
  - verilog/zxuno_pkg.sv
  - verilog/zxuno_port_decode.sv
  - verilog/zxuno_reg_bank.sv
  - verilog/zxuno_coreid.sv
  - verilog/cpu_din_mux.sv
  - verilog/zxuno_io.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_zxuno_io.sv
